//--- Makefile
VERILATOR ?= verilator
TOP       ?= dcfifo_tb
FILELIST  ?= dcfifo.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/dcfifo_tb.sv
// Dual-clock FIFO testbench
`timescale 1ns/1ps
`default_nettype none

module dcfifo_tb
    import dcfifo_pkg::*;
();

    // Cycle limit for every wait loop
    localparam int TIMEOUT  = 2000;
    // Sixteen memory entries plus the output stage
    localparam int CAPACITY = DEPTH + 1;

    logic                      in_clk = 1'b0;
    logic                      out_clk = 1'b0;
    logic                      in_reset_n;
    logic                      out_reset_n;
    logic [DATA_WIDTH-1:0]     in_data;
    logic                      in_valid;
    logic                      in_startofpacket;
    logic                      in_endofpacket;
    logic                      in_ready;
    logic [DATA_WIDTH-1:0]     out_data;
    logic                      out_valid;
    logic                      out_startofpacket;
    logic                      out_endofpacket;
    logic                      out_ready;
    logic                      in_csr_address;
    logic                      in_csr_read;
    logic                      in_csr_write;
    logic [CSR_DATA_WIDTH-1:0] in_csr_writedata;
    logic [CSR_DATA_WIDTH-1:0] in_csr_readdata;
    logic                      almost_full_valid;
    logic                      almost_full_data;

    // Beats accepted at the input and not yet seen at the output
    logic [PAYLOAD_WIDTH-1:0]  exp_q [$];
    logic [PAYLOAD_WIDTH-1:0]  out_beat;
    int                        received = 0;
    string                     current_test = "reset";

    dcfifo u_dcfifo (
        .in_clk            (in_clk),
        .in_reset_n        (in_reset_n),
        .out_clk           (out_clk),
        .out_reset_n       (out_reset_n),
        .in_data           (in_data),
        .in_valid          (in_valid),
        .in_startofpacket  (in_startofpacket),
        .in_endofpacket    (in_endofpacket),
        .in_ready          (in_ready),
        .out_data          (out_data),
        .out_valid         (out_valid),
        .out_startofpacket (out_startofpacket),
        .out_endofpacket   (out_endofpacket),
        .out_ready         (out_ready),
        .in_csr_address    (in_csr_address),
        .in_csr_read       (in_csr_read),
        .in_csr_write      (in_csr_write),
        .in_csr_writedata  (in_csr_writedata),
        .in_csr_readdata   (in_csr_readdata),
        .almost_full_valid (almost_full_valid),
        .almost_full_data  (almost_full_data)
    );

    // Write side 40 ns, read side 30 ns
    always #20 in_clk = ~in_clk;
    always #15 out_clk = ~out_clk;

    // ----------------------------------------------------------------------
    // Error reporting
    // ----------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
        stop_with_failure();
    endtask

    task automatic check_timeout(input int count, input string what);
        assert (count <= TIMEOUT) else begin
            $display("Timeout in %s while waiting for %s", current_test, what);
            stop_with_failure();
        end
    endtask

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // ----------------------------------------------------------------------
    // Stream monitors
    // ----------------------------------------------------------------------
    // Record each beat accepted at the input
    always @(posedge in_clk) begin
        if (in_reset_n && in_valid && in_ready) begin
            exp_q.push_back({in_startofpacket, in_endofpacket, in_data});
        end
    end

    // Compare each output beat in order with the recorded beats
    always @(posedge out_clk) begin
        if (out_reset_n && out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("Beat arrived at the output in %s with none outstanding",
                         current_test);
                stop_with_failure();
            end
            out_beat = exp_q.pop_front();
            assert ({out_startofpacket, out_endofpacket, out_data} == out_beat) else
                report_mismatch(current_test, 32'(out_beat),
                                32'({out_startofpacket, out_endofpacket, out_data}));
            received++;
        end
    end

    // ----------------------------------------------------------------------
    // Bus tasks
    // ----------------------------------------------------------------------
    task automatic set_out_ready(input logic value);
        @(posedge out_clk);
        out_ready <= value;
    endtask

    // Offer one beat and hold it until in_ready takes it
    task automatic send_beat(input logic sop, input logic eop,
                             input logic [DATA_WIDTH-1:0] data);
        int cycles;
        cycles = 0;
        @(posedge in_clk);
        in_startofpacket <= sop;
        in_endofpacket   <= eop;
        in_data          <= data;
        in_valid         <= 1'b1;
        do begin
            @(posedge in_clk);
            cycles++;
            check_timeout(cycles, "in_ready to accept a beat");
        end while (!in_ready);
        in_valid <= 1'b0;
    endtask

    task automatic send_packet(input int length, input logic [DATA_WIDTH-1:0] base);
        for (int i = 0; i < length; i++) begin
            send_beat(i == 0, i == length - 1, base + DATA_WIDTH'(i));
        end
    endtask

    task automatic csr_write(input logic addr, input logic [CSR_DATA_WIDTH-1:0] data);
        @(posedge in_clk);
        in_csr_address   <= addr;
        in_csr_writedata <= data;
        in_csr_write     <= 1'b1;
        @(posedge in_clk);
        in_csr_write <= 1'b0;
    endtask

    // Read data is registered one edge after the strobe
    task automatic csr_read(input logic addr, output logic [CSR_DATA_WIDTH-1:0] value);
        @(posedge in_clk);
        in_csr_address <= addr;
        in_csr_read    <= 1'b1;
        @(posedge in_clk);
        in_csr_read <= 1'b0;
        @(posedge in_clk);
        value = in_csr_readdata;
    endtask

    // First edge lets the input monitor record the last beat
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        @(posedge in_clk);
        while (exp_q.size() != 0) begin
            @(posedge out_clk);
            cycles++;
            check_timeout(cycles, "the output to drain");
        end
    endtask

    task automatic wait_almost_full(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge in_clk);
            cycles++;
            check_timeout(cycles, "almost_full_data to change");
        end while (almost_full_data != level);
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic pass_through();
        current_test = "pass_through";
        set_out_ready(1'b1);
        send_packet(3, 8'h10);
        send_packet(1, 8'h20);
        send_packet(4, 8'h30);
        wait_drained();
    endtask

    // Count accepted beats with the output stalled until in_ready stays low
    task automatic fill_to_full();
        int accepted;
        int low_cycles;
        int cycles;
        current_test = "fill_to_full";
        accepted   = 0;
        low_cycles = 0;
        cycles     = 0;
        set_out_ready(1'b0);
        @(posedge in_clk);
        in_startofpacket <= 1'b0;
        in_endofpacket   <= 1'b0;
        in_data          <= 8'h40;
        in_valid         <= 1'b1;
        while (low_cycles < 20) begin
            @(posedge in_clk);
            cycles++;
            check_timeout(cycles, "in_ready to stay low while filling");
            if (in_ready) begin
                accepted++;
                low_cycles = 0;
                in_data <= DATA_WIDTH'(8'h40 + accepted);
            end else begin
                low_cycles++;
            end
        end
        in_valid <= 1'b0;
        assert (accepted == CAPACITY) else report_mismatch(current_test, CAPACITY, accepted);
        set_out_ready(1'b1);
        wait_drained();
    endtask

    task automatic csr_readback();
        logic [CSR_DATA_WIDTH-1:0] value;
        int                        polls;
        current_test = "csr_readback";
        polls = 0;
        // Upper byte is dropped by the 24-bit threshold
        csr_write(CSR_ADDR_THRESH, 32'hA500_0123);
        csr_read(CSR_ADDR_THRESH, value);
        assert (value == 32'h0000_0123) else report_mismatch(current_test, 32'h123, value);
        set_out_ready(1'b0);
        send_packet(5, 8'h50);
        // One beat waits in the output stage, four in memory
        do begin
            csr_read(CSR_ADDR_FILL, value);
            polls++;
            check_timeout(polls, "the fill level to read 4");
        end while (value != 32'd4);
        set_out_ready(1'b1);
        wait_drained();
    endtask

    task automatic almost_full();
        current_test = "almost_full";
        csr_write(CSR_ADDR_THRESH, 32'd6);
        set_out_ready(1'b0);
        repeat (2) @(posedge in_clk);
        assert (almost_full_valid == 1'b1) else
            report_mismatch(current_test, 1, 32'(almost_full_valid));
        assert (almost_full_data == 1'b0) else
            report_mismatch(current_test, 0, 32'(almost_full_data));
        // Seven beats leave six in memory
        send_packet(7, 8'h60);
        wait_almost_full(1'b1);
        set_out_ready(1'b1);
        wait_drained();
        wait_almost_full(1'b0);
    endtask

    // Source and sink stall on LFSR bits in parallel
    task automatic random_stall();
        logic [15:0]           in_lfsr;
        logic [15:0]           out_lfsr;
        logic [DATA_WIDTH-1:0] rand_byte;
        int                    sent;
        int                    src_cycles;
        int                    sink_cycles;
        int                    start;
        current_test = "random_stall";
        in_lfsr     = 16'd98;
        out_lfsr    = 16'd98;
        rand_byte   = '0;
        sent        = 0;
        src_cycles  = 0;
        sink_cycles = 0;
        start       = received;
        fork
            begin
                while (sent < 40) begin
                    @(posedge in_clk);
                    src_cycles++;
                    check_timeout(src_cycles, "the source to send 40 beats");
                    if (in_valid && in_ready) begin
                        sent++;
                    end
                    if (sent < 40) begin
                        in_lfsr = lfsr_next(in_lfsr);
                        in_valid <= in_lfsr[0];
                        // Eight more bits for the data byte
                        for (int b = 0; b < DATA_WIDTH; b++) begin
                            in_lfsr   = lfsr_next(in_lfsr);
                            rand_byte = {rand_byte[DATA_WIDTH-2:0], in_lfsr[0]};
                        end
                        in_data          <= rand_byte;
                        in_startofpacket <= (sent == 0);
                        in_endofpacket   <= (sent == 39);
                    end else begin
                        in_valid <= 1'b0;
                    end
                end
            end
            begin
                while (received - start < 40) begin
                    @(posedge out_clk);
                    sink_cycles++;
                    check_timeout(sink_cycles, "40 beats at the output");
                    out_lfsr = lfsr_next(out_lfsr);
                    out_ready <= out_lfsr[0];
                end
                out_ready <= 1'b1;
            end
        join
        wait_drained();
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        in_reset_n       <= 1'b0;
        out_reset_n      <= 1'b0;
        in_data          <= '0;
        in_valid         <= 1'b0;
        in_startofpacket <= 1'b0;
        in_endofpacket   <= 1'b0;
        out_ready        <= 1'b0;
        in_csr_address   <= 1'b0;
        in_csr_read      <= 1'b0;
        in_csr_write     <= 1'b0;
        in_csr_writedata <= '0;

        // Each reset held for three cycles of its own clock
        fork
            begin
                repeat (3) @(posedge in_clk);
                in_reset_n <= 1'b1;
            end
            begin
                repeat (3) @(posedge out_clk);
                out_reset_n <= 1'b1;
            end
        join

        @(posedge in_clk);
        assert (in_ready == 1'b1) else report_mismatch(current_test, 1, 32'(in_ready));
        assert (out_valid == 1'b0) else report_mismatch(current_test, 0, 32'(out_valid));
        assert (in_csr_readdata == '0) else report_mismatch(current_test, 0, in_csr_readdata);

        pass_through();
        fill_to_full();
        csr_readback();
        almost_full();
        random_stall();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcfifo.f
source/dcfifo_pkg.sv
source/dcfifo_mem_if.sv
source/dcfifo_ram.sv
source/dcfifo_sync.sv
source/dcfifo_write_ctrl.sv
source/dcfifo_read_ctrl.sv
source/dcfifo_in_csr.sv
source/dcfifo.sv
bench/dcfifo_tb.sv

//--- source/dcfifo.sv
// Dual-clock streaming FIFO
`timescale 1ns/1ps
`default_nettype none

module dcfifo
    import dcfifo_pkg::*;
(
    // Write side clock and reset
    input  logic                      in_clk,
    input  logic                      in_reset_n,
    // Read side clock and reset
    input  logic                      out_clk,
    input  logic                      out_reset_n,
    // Input stream
    input  logic [DATA_WIDTH-1:0]     in_data,
    input  logic                      in_valid,
    input  logic                      in_startofpacket,
    input  logic                      in_endofpacket,
    output logic                      in_ready,
    // Output stream
    output logic [DATA_WIDTH-1:0]     out_data,
    output logic                      out_valid,
    output logic                      out_startofpacket,
    output logic                      out_endofpacket,
    input  logic                      out_ready,
    // Input register port
    input  logic                      in_csr_address,
    input  logic                      in_csr_read,
    input  logic                      in_csr_write,
    input  logic [CSR_DATA_WIDTH-1:0] in_csr_writedata,
    output logic [CSR_DATA_WIDTH-1:0] in_csr_readdata,
    // Input status
    output logic                      almost_full_valid,
    output logic                      almost_full_data
);

    // Pointers crossing between the two domains
    logic [PTR_WIDTH-1:0] wr_ptr_gray;
    logic [PTR_WIDTH-1:0] rd_ptr_gray;
    logic [PTR_WIDTH-1:0] fill_level;

    dcfifo_mem_if u_mem_if ();

    dcfifo_ram u_ram (
        .in_clk  (in_clk),
        .out_clk (out_clk),
        .mem     (u_mem_if.ram)
    );

    dcfifo_write_ctrl u_write_ctrl (
        .in_clk           (in_clk),
        .in_reset_n       (in_reset_n),
        .in_valid         (in_valid),
        .in_startofpacket (in_startofpacket),
        .in_endofpacket   (in_endofpacket),
        .in_data          (in_data),
        .in_ready         (in_ready),
        .mem              (u_mem_if.writer),
        .rd_ptr_gray      (rd_ptr_gray),
        .wr_ptr_gray      (wr_ptr_gray),
        .fill_level       (fill_level)
    );

    dcfifo_read_ctrl u_read_ctrl (
        .out_clk           (out_clk),
        .out_reset_n       (out_reset_n),
        .out_ready         (out_ready),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .out_startofpacket (out_startofpacket),
        .out_endofpacket   (out_endofpacket),
        .mem               (u_mem_if.reader),
        .wr_ptr_gray       (wr_ptr_gray),
        .rd_ptr_gray       (rd_ptr_gray)
    );

    dcfifo_in_csr u_in_csr (
        .in_clk            (in_clk),
        .in_reset_n        (in_reset_n),
        .in_csr_address    (in_csr_address),
        .in_csr_read       (in_csr_read),
        .in_csr_write      (in_csr_write),
        .in_csr_writedata  (in_csr_writedata),
        .fill_level        (fill_level),
        .in_csr_readdata   (in_csr_readdata),
        .almost_full_valid (almost_full_valid),
        .almost_full_data  (almost_full_data)
    );

endmodule

`default_nettype wire

//--- source/dcfifo_in_csr.sv
// Input register port and almost-full status
`timescale 1ns/1ps
`default_nettype none

module dcfifo_in_csr
    import dcfifo_pkg::*;
(
    input  logic                      in_clk,
    input  logic                      in_reset_n,
    input  logic                      in_csr_address,
    input  logic                      in_csr_read,
    input  logic                      in_csr_write,
    input  logic [CSR_DATA_WIDTH-1:0] in_csr_writedata,
    input  logic [PTR_WIDTH-1:0]      fill_level,
    output logic [CSR_DATA_WIDTH-1:0] in_csr_readdata,
    output logic                      almost_full_valid,
    output logic                      almost_full_data
);

    logic [THRESH_WIDTH-1:0] almost_full_threshold;
    logic [THRESH_WIDTH-1:0] fill_ext;

    assign fill_ext = THRESH_WIDTH'(fill_level);

    // ----------------------------------------------------------------------
    // Register access
    // ----------------------------------------------------------------------
    // Address 0 reads the fill level, address 1 holds the threshold
    // Write wins over a read in the same cycle
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            almost_full_threshold <= '0;
            in_csr_readdata       <= '0;
        end else if (in_csr_write) begin
            if (in_csr_address == CSR_ADDR_THRESH) begin
                almost_full_threshold <= in_csr_writedata[THRESH_WIDTH-1:0];
            end
        end else if (in_csr_read) begin
            // Reserved upper bits read as zero
            if (in_csr_address == CSR_ADDR_FILL) begin
                in_csr_readdata <= CSR_DATA_WIDTH'(fill_ext);
            end else begin
                in_csr_readdata <= CSR_DATA_WIDTH'(almost_full_threshold);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Almost-full status
    // ----------------------------------------------------------------------
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            almost_full_valid <= 1'b0;
            almost_full_data  <= 1'b0;
        end else begin
            almost_full_valid <= 1'b1;
            almost_full_data  <= fill_ext >= almost_full_threshold;
        end
    end

endmodule

`default_nettype wire

//--- source/dcfifo_mem_if.sv
// FIFO memory port bundle
`timescale 1ns/1ps
`default_nettype none

interface dcfifo_mem_if
    import dcfifo_pkg::*;
();

    // Write side, in_clk domain
    logic                     wr_en;
    logic [ADDR_WIDTH-1:0]    wr_addr;
    logic [PAYLOAD_WIDTH-1:0] wr_data;

    // Read side, out_clk domain
    logic [ADDR_WIDTH-1:0]    rd_addr;
    logic [PAYLOAD_WIDTH-1:0] rd_data;

    modport writer (output wr_en, output wr_addr, output wr_data);

    modport reader (output rd_addr, input rd_data);

    modport ram (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

//--- source/dcfifo_pkg.sv
// Dual-clock FIFO shared definitions
`default_nettype none

package dcfifo_pkg;

    // ----------------------------------------------------------------------
    // Storage sizes
    // ----------------------------------------------------------------------
    localparam int ADDR_WIDTH    = 4;
    localparam int DEPTH         = 2 ** ADDR_WIDTH;
    // One extra wrap bit tells full from empty
    localparam int PTR_WIDTH     = ADDR_WIDTH + 1;
    localparam int DATA_WIDTH    = 8;
    // Start-of-packet, end-of-packet, then the data beat
    localparam int PAYLOAD_WIDTH = DATA_WIDTH + 2;
    localparam int SYNC_STAGES   = 2;

    // ----------------------------------------------------------------------
    // Input register port
    // ----------------------------------------------------------------------
    localparam int   CSR_DATA_WIDTH  = 32;
    localparam int   THRESH_WIDTH    = 24;
    localparam logic CSR_ADDR_FILL   = 1'b0;
    localparam logic CSR_ADDR_THRESH = 1'b1;

    // ----------------------------------------------------------------------
    // Gray conversion
    // ----------------------------------------------------------------------
    // Adjacent values differ in one bit only
    function automatic logic [PTR_WIDTH-1:0] bin2gray(input logic [PTR_WIDTH-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits at or above it
    function automatic logic [PTR_WIDTH-1:0] gray2bin(input logic [PTR_WIDTH-1:0] gray);
        logic [PTR_WIDTH-1:0] bin;
        bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
        for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

//--- source/dcfifo_ram.sv
// Dual-clock payload memory
`timescale 1ns/1ps
`default_nettype none

module dcfifo_ram
    import dcfifo_pkg::*;
(
    input  logic         in_clk,
    input  logic         out_clk,
    dcfifo_mem_if.ram    mem
);

    // Simple dual-port array, one write port and one read port
    logic [PAYLOAD_WIDTH-1:0] mem_array [DEPTH];

    // Write port on the input clock
    always_ff @(posedge in_clk) begin
        if (mem.wr_en) begin
            mem_array[mem.wr_addr] <= mem.wr_data;
        end
    end

    // Registered read on the output clock
    // Address is the next read pointer, so data lines up with empty
    always_ff @(posedge out_clk) begin
        mem.rd_data <= mem_array[mem.rd_addr];
    end

endmodule

`default_nettype wire

//--- source/dcfifo_read_ctrl.sv
// FIFO read side control
`timescale 1ns/1ps
`default_nettype none

module dcfifo_read_ctrl
    import dcfifo_pkg::*;
(
    input  logic                  out_clk,
    input  logic                  out_reset_n,
    input  logic                  out_ready,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_startofpacket,
    output logic                  out_endofpacket,
    dcfifo_mem_if.reader          mem,
    input  logic [PTR_WIDTH-1:0]  wr_ptr_gray,
    output logic [PTR_WIDTH-1:0]  rd_ptr_gray
);

    logic                     empty;
    logic                     stage_ready;
    logic                     pop;
    logic [PTR_WIDTH-1:0]     rd_ptr;
    logic [PTR_WIDTH-1:0]     next_rd_ptr;
    logic [PTR_WIDTH-1:0]     wr_ptr_gray_sync;
    logic [PTR_WIDTH-1:0]     wr_ptr_bin;
    logic [PAYLOAD_WIDTH-1:0] out_payload;

    // ----------------------------------------------------------------------
    // Write pointer from the input domain
    // ----------------------------------------------------------------------
    dcfifo_sync #(.WIDTH(PTR_WIDTH), .STAGES(SYNC_STAGES)) u_wr_sync (
        .clk     (out_clk),
        .reset_n (out_reset_n),
        .din     (wr_ptr_gray),
        .dout    (wr_ptr_gray_sync)
    );

    assign wr_ptr_bin = gray2bin(wr_ptr_gray_sync);

    // ----------------------------------------------------------------------
    // Read pointer, empty flag
    // ----------------------------------------------------------------------
    // Output stage takes a beat when it is free or being drained
    assign stage_ready = out_ready || !out_valid;
    assign pop         = !empty && stage_ready;
    assign next_rd_ptr = rd_ptr + PTR_WIDTH'(pop);

    // Memory reads ahead at the next pointer
    assign mem.rd_addr = next_rd_ptr[ADDR_WIDTH-1:0];

    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            empty       <= 1'b1;
        end else begin
            rd_ptr      <= next_rd_ptr;
            rd_ptr_gray <= bin2gray(rd_ptr);
            empty       <= next_rd_ptr == wr_ptr_bin;
        end
    end

    // ----------------------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------------------
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            out_valid <= 1'b0;
        end else if (stage_ready) begin
            out_valid <= !empty;
        end
    end

    // Payload holds while stalled
    always_ff @(posedge out_clk) begin
        if (stage_ready) begin
            out_payload <= mem.rd_data;
        end
    end

    assign {out_startofpacket, out_endofpacket, out_data} = out_payload;

endmodule

`default_nettype wire

//--- source/dcfifo_sync.sv
// Gray pointer synchronizer
`timescale 1ns/1ps
`default_nettype none

module dcfifo_sync #(
    parameter int WIDTH  = 1,
    parameter int STAGES = 2
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // Register chain in the receiving domain
    logic [WIDTH-1:0] chain [STAGES];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < STAGES; i++) begin
                chain[i] <= '0;
            end
        end else begin
            // First stage may go metastable, later stages settle it
            chain[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign dout = chain[STAGES-1];

endmodule

`default_nettype wire

//--- source/dcfifo_write_ctrl.sv
// FIFO write side control
`timescale 1ns/1ps
`default_nettype none

module dcfifo_write_ctrl
    import dcfifo_pkg::*;
(
    input  logic                  in_clk,
    input  logic                  in_reset_n,
    input  logic                  in_valid,
    input  logic                  in_startofpacket,
    input  logic                  in_endofpacket,
    input  logic [DATA_WIDTH-1:0] in_data,
    output logic                  in_ready,
    dcfifo_mem_if.writer          mem,
    input  logic [PTR_WIDTH-1:0]  rd_ptr_gray,
    output logic [PTR_WIDTH-1:0]  wr_ptr_gray,
    output logic [PTR_WIDTH-1:0]  fill_level
);

    logic                 full;
    logic                 accept;
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] next_wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr_gray_sync;
    logic [PTR_WIDTH-1:0] rd_ptr_bin;

    // ----------------------------------------------------------------------
    // Write pointer and memory port
    // ----------------------------------------------------------------------
    assign in_ready    = !full;
    assign accept      = in_valid && in_ready;
    assign next_wr_ptr = wr_ptr + PTR_WIDTH'(accept);

    assign mem.wr_en   = accept;
    assign mem.wr_addr = wr_ptr[ADDR_WIDTH-1:0];
    assign mem.wr_data = {in_startofpacket, in_endofpacket, in_data};

    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
        end else begin
            wr_ptr      <= next_wr_ptr;
            // Registered so the crossing sees a glitch-free single-bit step
            wr_ptr_gray <= bin2gray(wr_ptr);
        end
    end

    // ----------------------------------------------------------------------
    // Read pointer from the output domain
    // ----------------------------------------------------------------------
    dcfifo_sync #(.WIDTH(PTR_WIDTH), .STAGES(SYNC_STAGES)) u_rd_sync (
        .clk     (in_clk),
        .reset_n (in_reset_n),
        .din     (rd_ptr_gray),
        .dout    (rd_ptr_gray_sync)
    );

    assign rd_ptr_bin = gray2bin(rd_ptr_gray_sync);

    // Full when addresses match and the wrap bits differ
    // Fill level excludes the output stage on the read side
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            full       <= 1'b0;
            fill_level <= '0;
        end else begin
            full       <= next_wr_ptr == {~rd_ptr_bin[PTR_WIDTH-1], rd_ptr_bin[ADDR_WIDTH-1:0]};
            fill_level <= next_wr_ptr - rd_ptr_bin;
        end
    end

endmodule

`default_nettype wire
